//--- logic/dma_cfg_pkg.sv
package dma_cfg_pkg;

	localparam int unsigned addr_width = 32;
	localparam int unsigned data_width = 64;

	localparam int unsigned max_burst = 16;
	localparam int unsigned beat_bytes = data_width / 8;
	localparam int unsigned burst_bytes = max_burst * beat_bytes;

	localparam int unsigned fifo_depth = 32;
	localparam int unsigned flush_idle_cycles = 16;

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [data_width-1:0] data_t;
	typedef logic [31:0] size_t;

	// one bit wider than the pointer so that a full FIFO can be told from an empty one.
	typedef logic [$clog2(fifo_depth + 1)-1:0] occ_t;

	// bit 0 pass done, bit 1 message end, bit 2 bus error.
	typedef logic [2:0] irq_t;

	// bit 0 busy, bit 1 slave error, bit 2 decode error.
	typedef logic [2:0] status_t;

endpackage

//--- logic/axi_pkg.sv
package axi_pkg;

	// AXI encodes the number of beats minus one.
	typedef logic [7:0] len_t;
	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay = 2'b00;
	localparam resp_t resp_slverr = 2'b10;
	localparam resp_t resp_decerr = 2'b11;

endpackage

//--- logic/stream_fifo.sv
module stream_fifo (
	input logic clk,
	input logic rst_n,

	input dma_cfg_pkg::data_t in_data,
	input logic in_last,
	input logic in_valid,
	output logic in_ready,

	output dma_cfg_pkg::data_t out_data,
	output logic out_last,
	input logic pop,
	output dma_cfg_pkg::occ_t occupancy
);
	import dma_cfg_pkg::*;

	typedef logic [$clog2(fifo_depth)-1:0] ptr_t;

	data_t data_mem [fifo_depth];
	logic last_mem [fifo_depth];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic push;
	logic full;
	logic empty;

	assign full = (occupancy == occ_t'(fifo_depth));
	assign empty = (occupancy == '0);
	assign in_ready = !full;
	assign push = in_valid && in_ready;

	// the head entry is always on the output, so a pop only moves the pointer.
	assign out_data = data_mem[rd_ptr];
	assign out_last = last_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			data_mem[wr_ptr] <= in_data;
			last_mem[wr_ptr] <= in_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + ptr_t'(1); // depth is a power of two so it wraps.
			end
			if (pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			case ({push, pop})
				2'b10: occupancy <= occupancy + occ_t'(1);
				2'b01: occupancy <= occupancy - occ_t'(1);
				default: occupancy <= occupancy;
			endcase
		end
	end

	// the engine pops on its own W handshake, so it must only do so with data present.
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop |-> !empty
	) else $error("stream_fifo popped while empty");

	// a stream beat that is offered stays put until the FIFO accepts it.
	a_in_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_last)
	) else $error("stream beat withdrawn before the FIFO accepted it");

endmodule

//--- logic/flush_ctrl.sv
module flush_ctrl (
	input logic clk,
	input logic rst_n,

	input logic beat,
	input dma_cfg_pkg::occ_t occupancy,

	output logic flush_req,
	output logic flush_ack
);
	import dma_cfg_pkg::*;

	typedef logic [$clog2(flush_idle_cycles + 1)-1:0] idle_cnt_t;

	idle_cnt_t idle_cnt;
	logic idle_done;
	logic partial;

	assign idle_done = (idle_cnt == idle_cnt_t'(flush_idle_cycles));

	// fewer beats than a full burst, so the engine would never pick them up alone.
	assign partial = (occupancy != '0) && (occupancy < occ_t'(max_burst));

	// the remainder has been written once the FIFO is empty again.
	assign flush_ack = flush_req && (occupancy == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idle_cnt <= '0;
			flush_req <= 1'b0;
		end else if (beat) begin
			idle_cnt <= '0; // any new beat cancels a pending flush.
			flush_req <= 1'b0;
		end else begin
			if (!idle_done) begin
				idle_cnt <= idle_cnt + idle_cnt_t'(1); // saturates at the idle limit.
			end
			if (idle_done && partial) begin
				flush_req <= 1'b1;
			end
		end
	end

endmodule

//--- logic/circular_dma_fsm.sv
module circular_dma_fsm (
	input logic clk,
	input logic rst_n,

	input logic flush_req,
	input logic flush_ack,
	input dma_cfg_pkg::occ_t occupancy,
	input dma_cfg_pkg::data_t fifo_data,
	input logic fifo_last,
	output logic fifo_pop,

	input logic enable,
	input dma_cfg_pkg::irq_t clear_irq,
	input dma_cfg_pkg::irq_t enable_irq,
	output dma_cfg_pkg::irq_t irq,
	output dma_cfg_pkg::status_t status_flags,

	input dma_cfg_pkg::addr_t mem_base,
	input dma_cfg_pkg::size_t mem_size,
	output dma_cfg_pkg::size_t bytes_written,
	output dma_cfg_pkg::size_t last_msg_end,

	output dma_cfg_pkg::addr_t m_axi_awaddr,
	output axi_pkg::len_t m_axi_awlen,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	output dma_cfg_pkg::data_t m_axi_wdata,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	input axi_pkg::resp_t m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);
	import dma_cfg_pkg::*;
	import axi_pkg::*;

	typedef enum logic [1:0] {
		wait_enable,
		write_addr,
		data_burst,
		wait_resp
	} state_t;

	state_t state;
	size_t mem_size_q;
	size_t last_msg_end_b;
	len_t burst_count;
	logic msg_end_seen;
	logic pass_end;

	function automatic size_t beats_to_bytes(input len_t beats);
		return size_t'(beats) * size_t'(beat_bytes);
	endfunction

	// checked when the response arrives, before bytes_written takes this burst in.
	assign pass_end = (bytes_written == mem_size_q) || !enable || (flush_req && flush_ack);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= wait_enable;
			irq <= '0;
			status_flags <= '0;
			bytes_written <= '0;
			last_msg_end <= '0;
			burst_count <= '0;
			msg_end_seen <= 1'b0;
			m_axi_awvalid <= 1'b0;
			m_axi_bready <= 1'b0;
		end else begin
			irq <= irq & ~clear_irq & enable_irq;

			case (state)
				wait_enable: begin
					if (enable && irq == '0 && mem_size >= size_t'(burst_bytes) && !flush_req) begin
						state <= write_addr;
						mem_size_q <= mem_size - size_t'(burst_bytes);
						bytes_written <= '0;
						last_msg_end <= '0;
						status_flags <= status_t'(1);
						burst_count <= '0;
						msg_end_seen <= 1'b0;
						m_axi_awaddr <= mem_base;
					end
				end

				write_addr: begin
					if (!m_axi_awvalid) begin
						if (!enable) begin
							state <= wait_enable;
							status_flags[0] <= 1'b0;
						end else if (occupancy >= occ_t'(max_burst)) begin
							m_axi_awlen <= len_t'(max_burst - 1);
							m_axi_awvalid <= 1'b1;
						end else if (flush_req && occupancy != '0) begin
							m_axi_awlen <= len_t'(occupancy) - len_t'(1); // short burst.
							m_axi_awvalid <= 1'b1;
						end
					end else if (m_axi_awready) begin
						state <= data_burst;
						m_axi_awaddr <= m_axi_awaddr + addr_t'(burst_bytes);
						m_axi_awvalid <= 1'b0;
						msg_end_seen <= 1'b0;
					end
				end

				data_burst: begin
					if (m_axi_wvalid && m_axi_wready) begin
						burst_count <= burst_count + len_t'(1);
						if (enable && fifo_last) begin
							msg_end_seen <= 1'b1;
							last_msg_end_b <= bytes_written + beats_to_bytes(burst_count + len_t'(1));
						end
						if (m_axi_wlast) begin
							state <= wait_resp;
							burst_count <= '0;
							m_axi_bready <= 1'b1;
						end
					end
				end

				wait_resp: begin
					if (m_axi_bvalid && m_axi_bready) begin
						m_axi_bready <= 1'b0;
						case (m_axi_bresp)
							resp_slverr, resp_decerr: begin
								state <= wait_enable;
								irq[2] <= enable_irq[2];
								status_flags <= {m_axi_bresp == resp_decerr,
									m_axi_bresp == resp_slverr, 1'b0};
							end
							default: begin
								bytes_written <= bytes_written + beats_to_bytes(m_axi_awlen + len_t'(1));
								if (msg_end_seen) begin
									last_msg_end <= last_msg_end_b; // committed only once the burst is safe.
									irq[1] <= enable_irq[1];
								end
								if (pass_end) begin
									state <= wait_enable;
									irq[0] <= enable_irq[0];
									status_flags[0] <= 1'b0;
								end else begin
									state <= write_addr;
								end
							end
						endcase
					end
				end

				default: state <= wait_enable;
			endcase
		end
	end

	always_comb begin
		m_axi_wdata = '0;
		m_axi_wvalid = 1'b0;
		m_axi_wlast = 1'b0;
		fifo_pop = 1'b0;
		if (state == data_burst) begin
			m_axi_wlast = (burst_count == m_axi_awlen);
			if (enable) begin
				m_axi_wdata = fifo_data;
				m_axi_wvalid = (occupancy != '0);
				fifo_pop = m_axi_wvalid && m_axi_wready;
			end else begin
				m_axi_wvalid = 1'b1; // pad the burst with zeros and leave the FIFO alone.
			end
		end
	end

	a_aw_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr)
	) else $error("awvalid dropped before awready");

	// a W beat on offer is held, wlast included, until the slave takes it.
	a_w_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wlast)
	) else $error("wvalid dropped before wready");

endmodule

//--- logic/circular_dma.sv
module circular_dma (
	input logic clk,
	input logic rst_n,

	input dma_cfg_pkg::data_t s_axis_tdata,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,
	output logic s_axis_tready,

	input logic enable,
	input dma_cfg_pkg::irq_t clear_irq,
	input dma_cfg_pkg::irq_t enable_irq,
	output dma_cfg_pkg::irq_t irq,
	output dma_cfg_pkg::status_t status_flags,

	input dma_cfg_pkg::addr_t mem_base,
	input dma_cfg_pkg::size_t mem_size,
	output dma_cfg_pkg::size_t bytes_written,
	output dma_cfg_pkg::size_t last_msg_end,

	output dma_cfg_pkg::addr_t m_axi_awaddr,
	output axi_pkg::len_t m_axi_awlen,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	output dma_cfg_pkg::data_t m_axi_wdata,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	input axi_pkg::resp_t m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);
	import dma_cfg_pkg::*;

	data_t fifo_data;
	logic fifo_last;
	logic fifo_pop;
	occ_t occupancy;
	logic beat;
	logic flush_req;
	logic flush_ack;

	assign beat = s_axis_tvalid && s_axis_tready; // an accepted stream beat.

	stream_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(s_axis_tdata),
		.in_last(s_axis_tlast),
		.in_valid(s_axis_tvalid),
		.in_ready(s_axis_tready),
		.out_data(fifo_data),
		.out_last(fifo_last),
		.pop(fifo_pop),
		.occupancy(occupancy)
	);

	flush_ctrl u_flush (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.occupancy(occupancy),
		.flush_req(flush_req),
		.flush_ack(flush_ack)
	);

	circular_dma_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.flush_req(flush_req),
		.flush_ack(flush_ack),
		.occupancy(occupancy),
		.fifo_data(fifo_data),
		.fifo_last(fifo_last),
		.fifo_pop(fifo_pop),
		.enable(enable),
		.clear_irq(clear_irq),
		.enable_irq(enable_irq),
		.irq(irq),
		.status_flags(status_flags),
		.mem_base(mem_base),
		.mem_size(mem_size),
		.bytes_written(bytes_written),
		.last_msg_end(last_msg_end),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awlen(m_axi_awlen),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata),
		.m_axi_wlast(m_axi_wlast),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bresp(m_axi_bresp),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready)
	);

endmodule

//--- verif/axi_mem_model.sv
module axi_mem_model (
	input logic clk,
	input logic rst_n,

	input dma_cfg_pkg::addr_t awaddr,
	input axi_pkg::len_t awlen,
	input logic awvalid,
	output logic awready,

	input dma_cfg_pkg::data_t wdata,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	output axi_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,

	input logic aw_stall,
	input logic w_stall,
	input logic b_stall,
	input dma_cfg_pkg::addr_t err_addr,
	input axi_pkg::resp_t err_resp
);
	timeunit 1ns;
	timeprecision 1ps;
	import dma_cfg_pkg::*;
	import axi_pkg::*;

	typedef enum logic [1:0] {
		idle,
		data,
		resp
	} phase_t;

	data_t mem [1024];
	phase_t phase;
	addr_t waddr;
	logic [9:0] wbeat;
	resp_t burst_resp;

	assign awready = (phase == idle) && !aw_stall;
	assign wready = (phase == data) && !w_stall;
	assign bresp = burst_resp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= idle;
			bvalid <= 1'b0;
			wbeat <= '0;
			waddr <= '0;
			burst_resp <= resp_okay;
		end else begin
			if (awvalid && awready) begin
				phase <= data;
				waddr <= awaddr;
				wbeat <= '0;
				burst_resp <= (awaddr == err_addr) ? err_resp : resp_okay; // injected error.
			end
			if (wvalid && wready) begin
				mem[waddr[12:3] + wbeat] <= wdata;
				wbeat <= wbeat + 10'd1;
				if (wlast) begin
					phase <= resp;
				end
			end
			if (phase == resp && !bvalid && !b_stall) begin
				bvalid <= 1'b1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				phase <= idle;
			end
		end
	end

endmodule

//--- verif/circular_dma_tb.sv
module circular_dma_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import dma_cfg_pkg::*;
	import axi_pkg::*;

	localparam int unsigned total_beats = 64 + 20 + 32 + 32 + 64;
	localparam int unsigned cycle_limit = 4 * total_beats + 200 * 5;

	logic clk;
	logic rst_n;
	data_t s_axis_tdata;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic s_axis_tready;
	logic enable;
	irq_t clear_irq;
	irq_t enable_irq;
	irq_t irq;
	status_t status_flags;
	addr_t mem_base;
	size_t mem_size;
	size_t bytes_written;
	size_t last_msg_end;
	addr_t awaddr;
	len_t awlen;
	logic awvalid;
	logic awready;
	data_t wdata;
	logic wlast;
	logic wvalid;
	logic wready;
	resp_t bresp;
	logic bvalid;
	logic bready;
	logic aw_stall;
	logic w_stall;
	logic b_stall;
	addr_t err_addr;
	resp_t err_resp;
	logic [31:0] stream_rng;
	logic [31:0] stall_rng;
	len_t aw_len_q;
	len_t w_beats;
	int unsigned cycles = 0;

	circular_dma dut (
		.clk(clk), .rst_n(rst_n),
		.s_axis_tdata(s_axis_tdata), .s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
		.enable(enable), .clear_irq(clear_irq), .enable_irq(enable_irq),
		.irq(irq), .status_flags(status_flags),
		.mem_base(mem_base), .mem_size(mem_size),
		.bytes_written(bytes_written), .last_msg_end(last_msg_end),
		.m_axi_awaddr(awaddr), .m_axi_awlen(awlen),
		.m_axi_awvalid(awvalid), .m_axi_awready(awready),
		.m_axi_wdata(wdata), .m_axi_wlast(wlast),
		.m_axi_wvalid(wvalid), .m_axi_wready(wready),
		.m_axi_bresp(bresp), .m_axi_bvalid(bvalid), .m_axi_bready(bready)
	);

	axi_mem_model u_mem (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.aw_stall(aw_stall), .w_stall(w_stall), .b_stall(b_stall),
		.err_addr(err_addr), .err_resp(err_resp)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// stream word for index n, distinct in both halves.
	function automatic data_t exp_word(input int unsigned n);
		return {~n, n * 32'h9e3779b9};
	endfunction

	task automatic stop_failed();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_size(input string name, input size_t exp, input size_t act);
		if (exp !== act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_irq(input string name, input irq_t exp, input irq_t act);
		if (exp !== act) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (exp !== act) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_len(input string name, input len_t exp, input len_t act);
		if (exp !== act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_mem(input string name, input addr_t base, input int first,
		input int count);
		for (int k = 0; k < count; k++) begin
			check_data(name, exp_word(first + k), u_mem.mem[int'(base >> 3) + k]);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	// pushes count words, tlast on index last_at; returns 5 ns after an edge.
	task automatic send_words(input int first, input int count, input int last_at);
		int i;
		logic taken;
		i = 0;
		taken = 1'b0;
		while (i < count) begin
			// a beat that is offered stays valid until the FIFO takes it.
			if (!s_axis_tvalid || taken) begin
				stream_rng = xorshift(stream_rng);
				s_axis_tvalid = (stream_rng[1:0] != 2'b00);
			end
			s_axis_tdata = exp_word(first + i);
			s_axis_tlast = (i == last_at);
			taken = s_axis_tvalid && s_axis_tready;
			step();
			if (taken) begin
				i++;
			end
		end
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic wait_irq(input irq_t mask);
		do begin
			step();
		end while ((irq & mask) == '0);
	endtask

	task automatic end_pass();
		enable = 1'b0;
		clear_irq = '1;
		step();
		clear_irq = '0;
		step();
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			#5;
			stall_rng = xorshift(stall_rng);
			aw_stall = stall_rng[0] & stall_rng[1];
			w_stall = stall_rng[2] & stall_rng[3];
			b_stall = stall_rng[4];
		end
	end

	// each burst must carry exactly the number of beats its AW announced.
	always @(negedge clk) begin
		if (rst_n && awvalid && awready) begin
			aw_len_q = awlen;
			w_beats = '0;
		end
		if (rst_n && wvalid && wready) begin
			if (wlast) begin
				check_len("burst length", w_beats, aw_len_q);
			end
			w_beats = w_beats + len_t'(1);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the DUT did not finish its passes within %0d cycles", cycle_limit);
			stop_failed();
		end
	end

	initial begin
		rst_n = 1'b0;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		enable = 1'b0;
		clear_irq = '0;
		enable_irq = 3'b111;
		mem_base = '0;
		mem_size = '0;
		aw_stall = 1'b0;
		w_stall = 1'b0;
		b_stall = 1'b0;
		err_addr = '1; // unreachable, so every burst is OKAY.
		err_resp = resp_okay;
		stream_rng = 32'hccc;
		stall_rng = 32'hccc ^ 32'h5555_0000;
		repeat (8) @(posedge clk);
		#5;
		rst_n = 1'b1;
		step();

		// full pass of four bursts with a message end on word 37.
		mem_base = 32'h100;
		mem_size = 4 * burst_bytes;
		enable = 1'b1;
		send_words(0, 64, 37);
		wait_irq(3'b001);
		check_mem("full_pass data", 32'h100, 0, 64);
		check_size("full_pass bytes_written", 4 * burst_bytes, bytes_written);
		check_size("msg_end last_msg_end", 38 * 8, last_msg_end);
		check_irq("full_pass irq", 3'b011, irq);
		check_status("full_pass status", 3'b000, status_flags);
		end_pass();

		// 20 words, then idle until the remainder is flushed.
		mem_base = 32'h800;
		enable = 1'b1;
		send_words(100, 20, -1);
		wait_irq(3'b001);
		check_mem("flush data", 32'h800, 100, 20);
		check_size("flush bytes_written", 160, bytes_written);
		check_irq("flush irq", 3'b001, irq);
		check_status("flush status", 3'b000, status_flags);
		end_pass();

		mem_base = 32'h1000;
		err_addr = 32'h1000 + burst_bytes;
		err_resp = resp_slverr;
		enable = 1'b1;
		send_words(200, 32, -1);
		wait_irq(3'b100);
		check_mem("slverr data", 32'h1000, 200, 16);
		check_size("slverr bytes_written", burst_bytes, bytes_written);
		check_irq("slverr irq", 3'b100, irq);
		check_status("slverr status", 3'b010, status_flags);
		end_pass();

		mem_base = 32'h1400;
		err_addr = 32'h1400 + burst_bytes;
		err_resp = resp_decerr;
		enable = 1'b1;
		send_words(300, 32, -1);
		wait_irq(3'b100);
		check_size("decerr bytes_written", burst_bytes, bytes_written);
		check_status("decerr status", 3'b100, status_flags);

		// the pending bus error must hold off the next pass, even with a full burst waiting.
		err_addr = '1;
		mem_base = 32'h100;
		enable_irq = 3'b110;
		send_words(1000, 16, -1);
		repeat (4) step();
		check_status("pending irq blocks start", 3'b100, status_flags);
		clear_irq = '1;
		step();
		clear_irq = '0;
		send_words(1016, 48, -1);
		do begin
			step();
		end while (status_flags[0]);
		check_size("masked bytes_written", 4 * burst_bytes, bytes_written);
		check_irq("masked irq", 3'b000, irq);
		enable = 1'b0;
		step();
		check_mem("rewrite data", 32'h100, 1000, 64);

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- filelist.f
logic/dma_cfg_pkg.sv
logic/axi_pkg.sv
logic/stream_fifo.sv
logic/flush_ctrl.sv
logic/circular_dma_fsm.sv
logic/circular_dma.sv
verif/axi_mem_model.sv
verif/circular_dma_tb.sv

//--- run_sim.sh
#!/bin/bash
# Compile and run the testbench with Verilator; fail if the log reports failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module circular_dma_tb -f filelist.f \
	-o circular_dma_sim > build.log 2>&1 \
	|| { echo "compile failed, see build.log"; exit 1; }
./obj_dir/circular_dma_sim > sim.log 2>&1
grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
	|| grep -q "Result: PASSED" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation ended without a verdict, see sim.log"; exit 1; }
